/* test/permute_trace.txt */
// columns: opcode, ra, word 0 of rb, i7, rt address, retire flag, expected value
// all hex, opcode numbers as in perm_op_t, bit 0 is the leftmost digit
// shift left by bits
0 00112233445566778899aabbccddeeff 00000000 00 01 1 00112233445566778899aabbccddeeff
0 80000000000000000000000000000001 00000007 00 02 1 00000000000000000000000000000080
0 00112233445566778899aabbccddeeff 0000000c 00 03 1 0112233445566778899aabbccddeeff0
// shift left by bits immediate
1 00112233445566778899aabbccddeeff 00000000 7b 04 1 0089119a22ab33bc44cd55de66ef77f8
1 80000000000000000000000000000001 00000000 78 05 1 80000000000000000000000000000001
// shift left by bytes
2 00112233445566778899aabbccddeeff 00000000 00 06 1 00112233445566778899aabbccddeeff
2 00112233445566778899aabbccddeeff ffffff07 00 07 1 778899aabbccddeeff00000000000000
2 00112233445566778899aabbccddeeff 0000000f 00 08 1 ff000000000000000000000000000000
2 00112233445566778899aabbccddeeff 00000010 00 09 1 00000000000000000000000000000000
2 00112233445566778899aabbccddeeff 000000ff 00 0a 1 00000000000000000000000000000000
// shift left by byte immediate
3 00112233445566778899aabbccddeeff 00000000 01 0b 1 112233445566778899aabbccddeeff00
3 00112233445566778899aabbccddeeff 00000000 0f 0c 1 ff000000000000000000000000000000
3 00112233445566778899aabbccddeeff 00000000 70 0d 1 00000000000000000000000000000000
// execute nop, no retirement
d 00112233445566778899aabbccddeeff 00000000 00 7f 0 00000000000000000000000000000000
// shift left by bytes from bit shift count
4 00112233445566778899aabbccddeeff 00000038 00 0e 1 778899aabbccddeeff00000000000000
4 00112233445566778899aabbccddeeff 0000003d 00 0f 1 778899aabbccddeeff00000000000000
4 00112233445566778899aabbccddeeff 00000080 00 10 1 00000000000000000000000000000000
// rotate by bytes
5 00112233445566778899aabbccddeeff 00000003 00 11 1 33445566778899aabbccddeeff001122
5 00112233445566778899aabbccddeeff 0000001f 00 12 1 ff00112233445566778899aabbccddee
// rotate by bytes immediate
6 00112233445566778899aabbccddeeff 00000000 07 13 1 778899aabbccddeeff00112233445566
6 00112233445566778899aabbccddeeff 00000000 10 14 1 00112233445566778899aabbccddeeff
// rotate by bytes from bit shift count, the second count is 20
7 00112233445566778899aabbccddeeff 00000028 00 15 1 5566778899aabbccddeeff0011223344
7 00112233445566778899aabbccddeeff 000000a0 00 16 1 445566778899aabbccddeeff00112233
// rotate by bits
8 80000000000000000000000000000001 00000001 00 17 1 00000000000000000000000000000003
8 f00000000000000000000000000000a5 00000004 00 18 1 00000000000000000000000000000a5f
// rotate by bits immediate
9 80000000000000000000000000000001 00000000 07 19 1 000000000000000000000000000000c0
9 00112233445566778899aabbccddeeff 00000000 7d 1a 1 022446688aaccef1133557799bbddfe0
// gather bits from bytes
a 0102030405060708090a0b0c0d0e0f10 00000000 00 1b 1 0000aaaa000000000000000000000000
a 00112233445566778899aabbccddeeff 00000000 00 1c 1 00005555000000000000000000000000
// gather bits from halfwords
b ff01ff00ff01ff01fe00fe00fe00ff01 00000000 00 1d 1 000000b1000000000000000000000000
b 0102030405060708090a0b0c0d0e0f10 00000000 00 1e 1 00000000000000000000000000000000
// gather bits from words
c 00000001fffffffe1234567989abcdef 00000000 00 1f 1 0000000b000000000000000000000000
// execute nop at the end of the trace
d 80000000000000000000000000000001 00000000 00 7e 0 00000000000000000000000000000000

/* files.f */
logic/permute_pkg.sv
logic/permute_issue.sv
logic/permute_lane.sv
logic/result_pipe.sv
logic/odd_permute_pipe.sv
test/odd_permute_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=odd_permute_pipe_tb

rm -f "$LOG_FILE"

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

# the log decides the result
if grep -qx "TESTS PASSED" "$LOG_FILE"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail"
exit 1

/* test/odd_permute_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module odd_permute_pipe_tb;
    import permute_pkg::*;

    localparam int TRACE_ENTRIES = 33;
    localparam int TRACE_FIELDS = 7;
    localparam int RANDOM_COUNT = 16;
    // from the edge that raises ack to the first edge that samples retire_valid high
    localparam int RETIRE_LATENCY = DEFAULT_PIPE_DEPTH;
    localparam int TIMEOUT_CYCLES = (TRACE_ENTRIES + RANDOM_COUNT) * 12 + 100;

    logic      clock = 1'b0;
    logic      reset;
    logic      req;
    perm_op_t  op;
    quadword_t ra;
    quadword_t rb;
    imm7_t     i7;
    reg_addr_t rt_address;
    logic      ack;
    logic      retire_valid;
    reg_addr_t retire_address;
    quadword_t retire_value;

    logic [127:0] trace_mem [0:TRACE_ENTRIES*TRACE_FIELDS-1];

    // expected retirements in issue order
    quadword_t value_q [$];
    reg_addr_t address_q [$];
    int        accept_cycle_q [$];

    // instruction currently on the request lines
    quadword_t pending_value;
    reg_addr_t pending_address;
    logic      pending_retire = 1'b0;

    int     cycle_count = 0;
    int     overlap_count = 0;
    logic   ack_prev = 1'b0;
    integer seed = 32'h21778471;

    odd_permute_pipe odd_permute_pipe_inst (
        .clock          (clock),
        .reset          (reset),
        .req            (req),
        .op             (op),
        .ra             (ra),
        .rb             (rb),
        .i7             (i7),
        .rt_address     (rt_address),
        .ack            (ack),
        .retire_valid   (retire_valid),
        .retire_address (retire_address),
        .retire_value   (retire_value)
    );

    always #50 clock = ~clock;

    task automatic halt_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input quadword_t actual,
                               input quadword_t expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            halt_on_failure();
        end
    endtask

    task automatic check_address(input string name, input reg_addr_t actual,
                                 input reg_addr_t expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            halt_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            halt_on_failure();
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            halt_on_failure();
        end
    endtask

    // rotate toward bit 0 by amount bits modulo 128
    function automatic quadword_t rotate_left(input quadword_t value, input int amount);
        return (value << amount) | (value >> (128 - amount));
    endfunction

    task automatic check_retirement();
        int accepted_at;
        if (value_q.size() == 0)
        begin
            $display("Error at %0t ns: a retirement arrived with no instruction outstanding",
                     $time);
            halt_on_failure();
        end
        else
        begin
            accepted_at = accept_cycle_q.pop_front();
            check_value("retire_value", retire_value, value_q.pop_front());
            check_address("retire_address", retire_address, address_q.pop_front());
            check_latency("retire latency", cycle_count - accepted_at, RETIRE_LATENCY);
            // a later handshake is open while this one retires
            if (req || ack)
                overlap_count++;
        end
    endtask

    // four-phase exchange for one instruction
    task automatic run_instruction(
        input perm_op_t  op_code,
        input quadword_t ra_value,
        input quadword_t rb_value,
        input imm7_t     imm_value,
        input reg_addr_t target,
        input logic      expect_retire,
        input quadword_t expect_value
    );
        pending_value = expect_value;
        pending_address = target;
        pending_retire = expect_retire;
        op <= op_code;
        ra <= ra_value;
        rb <= rb_value;
        i7 <= imm_value;
        rt_address <= target;
        req <= 1'b1;
        @(posedge clock);
        while (ack !== 1'b1)
            @(posedge clock);
        req <= 1'b0;
        @(posedge clock);
        while (ack !== 1'b0)
            @(posedge clock);
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            halt_on_failure();
        end
    end

    // scoreboard queues on each rising ack and checks each retirement
    always @(posedge clock)
    begin
        if (reset)
        begin
            ack_prev = 1'b0;
        end
        else
        begin
            // ack first seen high here was raised by the previous edge
            if (ack && !ack_prev && pending_retire)
            begin
                value_q.push_back(pending_value);
                address_q.push_back(pending_address);
                accept_cycle_q.push_back(cycle_count - 1);
            end
            if (retire_valid)
                check_retirement();
            ack_prev = ack;
        end
    end

    initial
    begin
        quadword_t random_ra;
        quadword_t random_rb;
        imm7_t     random_i7;
        int        base;
        reset = 1'b1;
        req = 1'b0;
        op = NOP_EXECUTE;
        ra = '0;
        rb = '0;
        i7 = '0;
        rt_address = '0;
        $readmemh("test/permute_trace.txt", trace_mem);

        repeat (10) @(posedge clock);
        reset <= 1'b0;
        check_flag("ack", ack, 1'b0);
        check_flag("retire_valid", retire_valid, 1'b0);
        repeat (2) @(posedge clock);

        // rb words 1 to 3 carry ones and only word 0 holds counts
        for (int entry = 0; entry < TRACE_ENTRIES; entry++)
        begin
            base = entry * TRACE_FIELDS;
            run_instruction(perm_op_t'(trace_mem[base][3:0]), trace_mem[base + 1],
                            {trace_mem[base + 2][31:0], 96'hffff_ffff_ffff_ffff_ffff_ffff},
                            trace_mem[base + 3][6:0], trace_mem[base + 4][6:0],
                            trace_mem[base + 5][0], trace_mem[base + 6]);
        end

        for (int k = 0; k < RANDOM_COUNT; k++)
        begin
            for (int w = 0; w < 4; w++)
            begin
                random_ra[w*32 +: 32] = $random(seed);
                random_rb[w*32 +: 32] = $random(seed);
            end
            random_i7 = 7'($random(seed));
            run_instruction(ROTATE_QUADWORD_BY_BITS_IMMEDIATE, random_ra, random_rb,
                            random_i7, 7'(32 + k), 1'b1,
                            rotate_left(random_ra, int'(random_i7[4:6])));
        end

        while (value_q.size() != 0)
            @(posedge clock);
        // margin for a stray retirement after the last one
        repeat (2 * DEFAULT_PIPE_DEPTH) @(posedge clock);

        if (overlap_count > 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("Error: no retirement arrived while a later handshake was open");
            halt_on_failure();
        end
    end

endmodule

`default_nettype wire

/* logic/odd_permute_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module odd_permute_pipe #(
    parameter int PIPE_DEPTH = permute_pkg::DEFAULT_PIPE_DEPTH
) (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       req,
    input  wire permute_pkg::perm_op_t      op,
    input  wire permute_pkg::quadword_t     ra,
    input  wire permute_pkg::quadword_t     rb,
    input  wire permute_pkg::imm7_t         i7,
    input  wire permute_pkg::reg_addr_t     rt_address,
    output logic                            ack,
    output logic                            retire_valid,
    output permute_pkg::reg_addr_t          retire_address,
    output permute_pkg::quadword_t          retire_value
);
    import permute_pkg::*;

    // operands and controls as captured by the issue unit
    quadword_t    issue_ra;
    byte_count_t  byte_count;
    bit_count_t   bit_count;
    logic         rotate;
    gather_mode_t gather_mode;
    reg_addr_t    issue_rt_address;
    logic         issue_valid;

    // one byte per lane, lane 0 in the most significant byte
    quadword_t    lane_bytes;

    permute_issue permute_issue_inst (
        .clock         (clock),
        .reset         (reset),
        .req           (req),
        .op            (op),
        .rb_in         (rb),
        .ra_in         (ra),
        .i7            (i7),
        .rt_address_in (rt_address),
        .ack           (ack),
        .issue_valid   (issue_valid),
        .ra            (issue_ra),
        .byte_count    (byte_count),
        .bit_count     (bit_count),
        .rotate        (rotate),
        .gather_mode   (gather_mode),
        .rt_address    (issue_rt_address)
    );

    for (genvar lane = 0; lane < LANES; lane++)
    begin : g_lane
        permute_lane #(
            .LANE_INDEX (lane)
        ) permute_lane_inst (
            .ra         (issue_ra),
            .byte_count (byte_count),
            .bit_count  (bit_count),
            .rotate     (rotate),
            .lane_byte  (lane_bytes[lane*8 +: 8])
        );
    end

    result_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) result_pipe_inst (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .lane_bytes     (lane_bytes),
        .ra             (issue_ra),
        .gather_mode    (gather_mode),
        .rt_address     (issue_rt_address),
        .retire_valid   (retire_valid),
        .retire_address (retire_address),
        .retire_value   (retire_value)
    );

endmodule

`default_nettype wire

/* logic/result_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module result_pipe #(
    parameter int PIPE_DEPTH = permute_pkg::DEFAULT_PIPE_DEPTH
) (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       issue_valid,
    input  wire permute_pkg::quadword_t     lane_bytes,
    input  wire permute_pkg::quadword_t     ra,
    input  wire permute_pkg::gather_mode_t  gather_mode,
    input  wire permute_pkg::reg_addr_t     rt_address,
    output logic                            retire_valid,
    output permute_pkg::reg_addr_t          retire_address,
    output permute_pkg::quadword_t          retire_value
);
    import permute_pkg::*;

    localparam int STAGES = PIPE_DEPTH - 1;

    logic [0:LANES-1]   byte_bits;
    logic [0:LANES/2-1] halfword_bits;
    logic [0:LANES/4-1] word_bits;
    quadword_t          assembled_value;

    logic [1:STAGES]    stage_valid;
    quadword_t          stage_value [1:STAGES];
    reg_addr_t          stage_address [1:STAGES];

    // low bit of each element, element 0 ends up leftmost in the field
    always_comb
    begin
        for (int j = 0; j < LANES; j++)
            byte_bits[j] = ra[8*j + 7];
        for (int j = 0; j < LANES/2; j++)
            halfword_bits[j] = ra[16*j + 15];
        for (int j = 0; j < LANES/4; j++)
            word_bits[j] = ra[32*j + 31];
    end

    always_comb
    begin
        assembled_value = '0;
        case (gather_mode)
            GATHER_BYTES:
                assembled_value[16:31] = byte_bits;
            GATHER_HALFWORDS:
                assembled_value[24:31] = halfword_bits;
            GATHER_WORDS:
                assembled_value[28:31] = word_bits;
            default:
                assembled_value = lane_bytes;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_valid <= '0;
        end
        else
        begin
            stage_valid[1] <= issue_valid;
            for (int s = 2; s <= STAGES; s++)
                stage_valid[s] <= stage_valid[s-1];
        end
    end

    // first stage only loads on a new instruction, the rest just shift
    always_ff @(posedge clock)
    begin
        if (issue_valid)
        begin
            stage_value[1] <= assembled_value;
            stage_address[1] <= rt_address;
        end
        for (int s = 2; s <= STAGES; s++)
        begin
            stage_value[s] <= stage_value[s-1];
            stage_address[s] <= stage_address[s-1];
        end
    end

    assign retire_valid = stage_valid[STAGES];
    assign retire_value = stage_value[STAGES];
    assign retire_address = stage_address[STAGES];

endmodule

`default_nettype wire

/* logic/permute_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module permute_lane #(
    parameter int LANE_INDEX = 0
) (
    input  wire permute_pkg::quadword_t     ra,
    input  wire permute_pkg::byte_count_t   byte_count,
    input  wire permute_pkg::bit_count_t    bit_count,
    input  wire logic                       rotate,
    output permute_pkg::byte_t              lane_byte
);
    import permute_pkg::*;

    localparam int BYTE_BITS = $bits(byte_t);

    // source byte of ra, zero when the index runs past the last lane
    function automatic byte_t byte_at(quadword_t value, logic [0:5] index);
        byte_t selected;
        selected = '0;
        if (index < LANES)
        begin
            selected = value[index*BYTE_BITS +: BYTE_BITS];
        end
        return selected;
    endfunction

    logic [0:5]  first_index;
    logic [0:5]  second_index;
    byte_t       first_byte;
    byte_t       second_byte;
    logic [0:15] shifted_pair;

    always_comb
    begin
        first_index = 6'(LANE_INDEX) + 6'(byte_count);
        second_index = first_index + 6'd1;
        // rotation keeps only the low four index bits
        if (rotate)
        begin
            first_index[0:1] = 2'b00;
            second_index[0:1] = 2'b00;
        end
    end

    assign first_byte = byte_at(ra, first_index);
    assign second_byte = byte_at(ra, second_index);

    // bits shifted out of the next byte fill the low end of this one
    assign shifted_pair = {first_byte, second_byte} << bit_count;
    assign lane_byte = shifted_pair[0:BYTE_BITS-1];

endmodule

`default_nettype wire

/* logic/permute_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module permute_issue (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       req,
    input  wire permute_pkg::perm_op_t      op,
    input  wire permute_pkg::quadword_t     rb_in,
    input  wire permute_pkg::quadword_t     ra_in,
    input  wire permute_pkg::imm7_t         i7,
    input  wire permute_pkg::reg_addr_t     rt_address_in,
    output logic                            ack,
    output logic                            issue_valid,
    output permute_pkg::quadword_t          ra,
    output permute_pkg::byte_count_t        byte_count,
    output permute_pkg::bit_count_t         bit_count,
    output logic                            rotate,
    output permute_pkg::gather_mode_t       gather_mode,
    output permute_pkg::reg_addr_t          rt_address
);
    import permute_pkg::*;

    issue_state_t state;
    logic         accept;

    byte_count_t  next_byte_count;
    bit_count_t   next_bit_count;
    logic         next_rotate;
    gather_mode_t next_gather_mode;

    // ack is high for the whole time the request is being released
    assign ack = (state == WAIT_RELEASE);
    assign accept = req && (state == WAIT_REQ);

    // opcode and immediate fields turn into lane shift controls
    always_comb
    begin
        next_byte_count = '0;
        next_bit_count = '0;
        next_rotate = 1'b0;
        next_gather_mode = NO_GATHER;
        case (op)
            SHIFT_LEFT_QUADWORD_BY_BITS:
                next_bit_count = rb_in[29:31];
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:
                next_bit_count = i7[4:6];
            SHIFT_LEFT_QUADWORD_BY_BYTES:
                next_byte_count = rb_in[27:31];
            SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE:
                next_byte_count = i7[2:6];
            SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT:
                next_byte_count = rb_in[24:28];
            ROTATE_QUADWORD_BY_BYTES:
            begin
                next_byte_count = {1'b0, rb_in[28:31]};
                next_rotate = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
            begin
                next_byte_count = {1'b0, i7[3:6]};
                next_rotate = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT:
            begin
                // the lanes wrap their indices, so counts above 15 act modulo 16
                next_byte_count = rb_in[24:28];
                next_rotate = 1'b1;
            end
            ROTATE_QUADWORD_BY_BITS:
            begin
                next_bit_count = rb_in[29:31];
                next_rotate = 1'b1;
            end
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
            begin
                next_bit_count = i7[4:6];
                next_rotate = 1'b1;
            end
            GATHER_BITS_FROM_BYTES:
                next_gather_mode = GATHER_BYTES;
            GATHER_BITS_FROM_HALFWORDS:
                next_gather_mode = GATHER_HALFWORDS;
            GATHER_BITS_FROM_WORDS:
                next_gather_mode = GATHER_WORDS;
            default:
                next_gather_mode = NO_GATHER;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= WAIT_REQ;
            issue_valid <= 1'b0;
        end
        else
        begin
            // one pulse per accepted request, none for the nop
            issue_valid <= accept && (op != NOP_EXECUTE);
            case (state)
                WAIT_REQ:
                    if (req)
                        state <= WAIT_RELEASE;
                WAIT_RELEASE:
                    if (!req)
                        state <= WAIT_REQ;
                default:
                    state <= WAIT_REQ;
            endcase
        end
    end

    // operands and decoded controls hold until the next request is taken
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            ra <= ra_in;
            byte_count <= next_byte_count;
            bit_count <= next_bit_count;
            rotate <= next_rotate;
            gather_mode <= next_gather_mode;
            rt_address <= rt_address_in;
        end
    end

endmodule

`default_nettype wire

/* logic/permute_pkg.sv */
`default_nettype none

package permute_pkg;

    // bit 0 is the most significant bit in every vector below
    typedef logic [0:127] quadword_t;
    typedef logic [0:7]   byte_t;
    typedef logic [0:6]   reg_addr_t;
    typedef logic [0:6]   imm7_t;

    // byte shift count covers 0 to 31, bit shift count 0 to 7
    typedef logic [0:4]   byte_count_t;
    typedef logic [0:2]   bit_count_t;

    // number of byte lanes across one quadword
    localparam int LANES = 16;

    // cycles from acceptance to retirement unless the top level overrides it
    localparam int DEFAULT_PIPE_DEPTH = 4;

    // opcode numbers are fixed so that a trace file can name them directly
    typedef enum logic [0:3] {
        SHIFT_LEFT_QUADWORD_BY_BITS                   = 4'd0,
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE         = 4'd1,
        SHIFT_LEFT_QUADWORD_BY_BYTES                  = 4'd2,
        SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE         = 4'd3,
        SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT   = 4'd4,
        ROTATE_QUADWORD_BY_BYTES                      = 4'd5,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE            = 4'd6,
        ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT       = 4'd7,
        ROTATE_QUADWORD_BY_BITS                       = 4'd8,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE             = 4'd9,
        GATHER_BITS_FROM_BYTES                        = 4'd10,
        GATHER_BITS_FROM_HALFWORDS                    = 4'd11,
        GATHER_BITS_FROM_WORDS                        = 4'd12,
        NOP_EXECUTE                                   = 4'd13
    } perm_op_t;

    // which element size the gather collects from, if any
    typedef enum logic [0:1] {
        NO_GATHER        = 2'd0,
        GATHER_BYTES     = 2'd1,
        GATHER_HALFWORDS = 2'd2,
        GATHER_WORDS     = 2'd3
    } gather_mode_t;

    // four-phase handshake on the issue side
    typedef enum logic {
        WAIT_REQ     = 1'b0,
        WAIT_RELEASE = 1'b1
    } issue_state_t;

endpackage

`default_nettype wire
